// ==== vp.f ====
+incdir+rtl
rtl/vp_pkg.sv
rtl/vp_image_cut.sv
rtl/vp_line_filter.sv
rtl/vp_fill_blank.sv
rtl/vp_top.sv
testbench/tb_clock_gen.sv
testbench/tb_vp_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video path testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vp_top -f vp.f \
    -o tb_vp_top_sim \
    && ./obj_dir/tb_vp_top_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

// ==== testbench/tb_vp_top.sv ====
`default_nettype none

module tb_vp_top;

    localparam int H_DISP    = 8;
    localparam int V_LINES   = 4;
    localparam int LINE_GAP  = H_DISP + 2;
    // vs, three blank cycles, then every line with its gap
    localparam int FRAME_CYC = 4 + V_LINES * (H_DISP + LINE_GAP);
    localparam int DRV_DLY   = 10;
    localparam int MAX_ROWS  = 8;

    logic                 clk;
    logic                 rst;
    logic                 vi_vs;
    logic                 vi_de;
    vp_pkg::rgb565_t      vi_data;
    vp_pkg::filter_mode_t mode;
    vp_pkg::coord_t       start_x;
    vp_pkg::coord_t       start_y;
    vp_pkg::coord_t       end_x;
    vp_pkg::coord_t       end_y;
    logic                 vp_vs;
    logic                 vp_de;
    vp_pkg::rgb565_t      vp_data;

    // test table with one row per test
    string row_name   [MAX_ROWS];
    int    row_mode   [MAX_ROWS];
    int    row_sx     [MAX_ROWS];
    int    row_sy     [MAX_ROWS];
    int    row_ex     [MAX_ROWS];
    int    row_ey     [MAX_ROWS];
    int    row_frames [MAX_ROWS];
    int    n_rows;

    integer          seed;
    vp_pkg::rgb565_t frame_px [V_LINES][H_DISP];

    // expected output that the model fills ahead of the DUT
    logic [15:0] exp_q [$];
    int          exp_row_q [$];
    int          vs_cyc_q [$];
    int          vs_row_q [$];

    int          cycle_cnt;
    int          timeout_cyc;
    logic        frame_started;
    int          pix_errs;
    int          other_errs;
    logic        de_prev;
    logic        vs_prev;
    int          run_len;
    int          last_row;
    logic [15:0] exp_px;
    int          exp_cyc;

    tb_clock_gen #(
        .PERIOD    (100),
        .RST_CYCLES(8)
    ) u_clock_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    vp_top #(
        .H_DISP(H_DISP)
    ) UUT (
        .clk_vpm  (clk),
        .rst_i    (rst),
        .vi_vs_i  (vi_vs),
        .vi_de_i  (vi_de),
        .vi_data_i(vi_data),
        .mode_i   (mode),
        .start_x_i(start_x),
        .start_y_i(start_y),
        .end_x_i  (end_x),
        .end_y_i  (end_y),
        .vp_vs_o  (vp_vs),
        .vp_de_o  (vp_de),
        .vp_data_o(vp_data)
    );

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    // each 565 channel lands at the top of its byte
    function automatic logic [23:0] unpack565(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic logic [15:0] pack888(input logic [23:0] p);
        return {p[23:19], p[15:10], p[7:3]};
    endfunction

    // three tap kernel per channel
    // modes other than 1 and 2 pass c
    function automatic logic [23:0] filter_pixel(input int fmode, input logic [23:0] l,
                                                 input logic [23:0] c, input logic [23:0] r);
        logic [23:0] res;
        int          a;
        int          b;
        int          d;
        int          hi;
        int          lo;
        int          ch;
        res = c;
        for (ch = 0; ch < 3; ch++) begin
            a  = int'(l[ch*8 +: 8]);
            b  = int'(c[ch*8 +: 8]);
            d  = int'(r[ch*8 +: 8]);
            hi = (a > b) ? a : b;
            hi = (hi > d) ? hi : d;
            lo = (a < b) ? a : b;
            lo = (lo < d) ? lo : d;
            if (fmode == 1) begin
                res[ch*8 +: 8] = 8'((a + 2 * b + d) / 4);
            end else if (fmode == 2) begin
                // middle value is the sum minus both extremes
                res[ch*8 +: 8] = 8'(a + b + d - hi - lo);
            end
        end
        return res;
    endfunction

    // crop, filter, pad and pack one frame into the expected queue
    task automatic model_frame(input int t);
        logic [23:0] line_q [$];
        logic [23:0] l;
        logic [23:0] r;
        int          y;
        int          x;
        int          n;
        for (y = row_sy[t]; y < row_ey[t] && y < V_LINES; y++) begin
            line_q.delete();
            for (x = row_sx[t]; x < row_ex[t] && x < H_DISP; x++) begin
                line_q.push_back(unpack565(frame_px[y][x]));
            end
            n = line_q.size();
            for (x = 0; x < n; x++) begin
                // edge pixels stand in for their missing neighbor
                l = (x == 0) ? line_q[x] : line_q[x-1];
                r = (x == n - 1) ? line_q[x] : line_q[x+1];
                exp_q.push_back(pack888(filter_pixel(row_mode[t], l, line_q[x], r)));
                exp_row_q.push_back(t);
            end
            for (x = n; x < H_DISP && n > 0; x++) begin
                exp_q.push_back(16'h0000);
                exp_row_q.push_back(t);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic add_row(input string name, input int fmode, input int sx, input int sy,
                           input int ex, input int ey, input int frames);
        row_name[n_rows]   = name;
        row_mode[n_rows]   = fmode;
        row_sx[n_rows]     = sx;
        row_sy[n_rows]     = sy;
        row_ex[n_rows]     = ex;
        row_ey[n_rows]     = ey;
        row_frames[n_rows] = frames;
        n_rows++;
    endtask

    // inputs change a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic fill_frame();
        int y;
        int x;
        for (y = 0; y < V_LINES; y++) begin
            for (x = 0; x < H_DISP; x++) begin
                frame_px[y][x] = vp_pkg::rgb565_t'($random(seed));
            end
        end
    endtask

    task automatic drive_line(input int y);
        int x;
        for (x = 0; x < H_DISP; x++) begin
            vi_de   = 1'b1;
            vi_data = frame_px[y][x];
            next_cycle();
        end
        vi_de   = 1'b0;
        vi_data = '0;
        repeat (LINE_GAP) next_cycle();
    endtask

    task automatic drive_frame(input int t);
        int y;
        fill_frame();
        model_frame(t);
        // controls change only on the vs cycle
        // the previous frame has long left the filter by then
        mode          = vp_pkg::filter_mode_t'(row_mode[t]);
        start_x       = vp_pkg::coord_t'(row_sx[t]);
        start_y       = vp_pkg::coord_t'(row_sy[t]);
        end_x         = vp_pkg::coord_t'(row_ex[t]);
        end_y         = vp_pkg::coord_t'(row_ey[t]);
        vi_vs         = 1'b1;
        frame_started = 1'b1;
        vs_cyc_q.push_back(cycle_cnt);
        vs_row_q.push_back(t);
        next_cycle();
        vi_vs = 1'b0;
        repeat (3) next_cycle();
        for (y = 0; y < V_LINES; y++) begin
            drive_line(y);
        end
    endtask

    initial begin
        int t;
        int f;
        vi_vs         = 1'b0;
        vi_de         = 1'b0;
        vi_data       = '0;
        mode          = '0;
        start_x       = '0;
        start_y       = '0;
        end_x         = vp_pkg::coord_t'(H_DISP);
        end_y         = vp_pkg::coord_t'(V_LINES);
        seed          = 32'h2f39_445d;
        frame_started = 1'b0;
        pix_errs      = 0;
        other_errs    = 0;
        n_rows        = 0;
        timeout_cyc   = 0;

        //      name            mode sx sy ex ey frames
        add_row("bypass_full",  0,   0, 0, 8, 4, 2);
        add_row("gauss_full",   1,   0, 0, 8, 4, 2);
        add_row("median_full",  2,   0, 0, 8, 4, 2);
        add_row("mode3_bypass", 3,   0, 0, 8, 4, 1);
        add_row("crop_gauss",   1,   2, 1, 6, 3, 2);
        add_row("crop_median",  2,   2, 1, 6, 3, 1);

        for (t = 0; t < n_rows; t++) begin
            timeout_cyc += 2 * row_frames[t] * FRAME_CYC;
        end

        @(negedge rst);
        repeat (4) next_cycle();
        // a line with no vs in front of it
        // the crop stage must drop it
        fill_frame();
        drive_line(0);

        for (t = 0; t < n_rows; t++) begin
            for (f = 0; f < row_frames[t]; f++) begin
                drive_frame(t);
            end
        end
        repeat (3 * H_DISP) next_cycle();

        assert (exp_q.size() == 0) else begin
            $display("%0d expected pixels never came out", exp_q.size());
            other_errs++;
        end
        assert (vs_cyc_q.size() == 0) else begin
            $display("%0d input frames got no output vs", vs_cyc_q.size());
            other_errs++;
        end
        $display("checks done: %0d pixel errors, %0d other errors", pix_errs, other_errs);
        if (pix_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // cycle count and timeout
    // ----------------------------------------------------------------------
    initial begin
        cycle_cnt = 0;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_cyc > 0 && cycle_cnt >= timeout_cyc) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // output monitor sampled at the falling edge
    // ----------------------------------------------------------------------
    initial begin
        de_prev  = 1'b0;
        vs_prev  = 1'b0;
        run_len  = 0;
        last_row = 0;
    end

    always @(negedge clk) begin
        // outputs hold no value before the first rising edge
        if (!frame_started && cycle_cnt > 0) begin
            assert (vp_de === 1'b0 && vp_vs === 1'b0) else begin
                $display("output de or vs active before the first input frame");
                other_errs++;
            end
        end

        // vs leaves four cycles after it went in
        if (vp_vs === 1'b1 && !vs_prev) begin
            if (vs_cyc_q.size() == 0) begin
                $display("output vs with no input vs in front of it");
                other_errs++;
            end else begin
                exp_cyc  = vs_cyc_q.pop_front() + 4;
                last_row = vs_row_q.pop_front();
                assert (cycle_cnt == exp_cyc) else begin
                    $display("Error: %s vs cycle expected %0d actual %0d",
                             row_name[last_row], exp_cyc, cycle_cnt);
                    other_errs++;
                end
            end
        end

        if (vp_de === 1'b1) begin
            run_len++;
            if (exp_q.size() == 0) begin
                $display("output pixel with no expected pixel left");
                other_errs++;
            end else begin
                exp_px   = exp_q.pop_front();
                last_row = exp_row_q.pop_front();
                assert (vp_data === exp_px) else begin
                    $display("Error: %s pixel expected %h actual %h",
                             row_name[last_row], exp_px, vp_data);
                    pix_errs++;
                end
            end
        end else if (de_prev) begin
            // every output line is exactly H_DISP long
            assert (run_len == H_DISP) else begin
                $display("Error: %s line length expected %0d actual %0d",
                         row_name[last_row], H_DISP, run_len);
                other_errs++;
            end
            run_len = 0;
        end

        de_prev = (vp_de === 1'b1);
        vs_prev = (vp_vs === 1'b1);
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    // free running clock, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // reset high from time zero and seen on RST_CYCLES rising edges
    // released a little after the last of them, like the other inputs
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #(PERIOD / 10) rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== rtl/vp_top.sv ====
`default_nettype none

`include "vp_config.svh"

module vp_top #(
    parameter int H_DISP = `VP_H_DISP_DEFAULT
) (
    input  wire                       clk_vpm,
    input  wire                       rst_i,

    // video input, rgb565
    input  wire                       vi_vs_i,
    input  wire                       vi_de_i,
    input  wire vp_pkg::rgb565_t      vi_data_i,

    // run time controls, steady during a frame
    input  wire vp_pkg::filter_mode_t mode_i,
    input  wire vp_pkg::coord_t       start_x_i,
    input  wire vp_pkg::coord_t       start_y_i,
    input  wire vp_pkg::coord_t       end_x_i,
    input  wire vp_pkg::coord_t       end_y_i,

    // processed video, rgb565, 4 cycles behind the input
    output logic                      vp_vs_o,
    output logic                      vp_de_o,
    output vp_pkg::rgb565_t           vp_data_o
);

    logic            cut_vs;
    logic            cut_de;
    vp_pkg::rgb888_t cut_data;

    logic            filt_vs;
    logic            filt_de;
    vp_pkg::rgb888_t filt_data;

    // ---------------------------------------------------------------------
    // input side, unpack and crop (1 cycle)
    // ---------------------------------------------------------------------
    vp_image_cut #(
        .H_DISP(H_DISP)
    ) u_image_cut (
        .clk_vpm  (clk_vpm),
        .rst_i    (rst_i),
        .vs_i     (vi_vs_i),
        .de_i     (vi_de_i),
        .data_i   (vi_data_i),
        .start_x_i(start_x_i),
        .start_y_i(start_y_i),
        .end_x_i  (end_x_i),
        .end_y_i  (end_y_i),
        .vs_o     (cut_vs),
        .de_o     (cut_de),
        .data_o   (cut_data)
    );

    // ---------------------------------------------------------------------
    // processing, three tap line filter (2 cycles)
    // ---------------------------------------------------------------------
    vp_line_filter u_line_filter (
        .clk_vpm(clk_vpm),
        .rst_i  (rst_i),
        .mode_i (mode_i),
        .vs_i   (cut_vs),
        .de_i   (cut_de),
        .data_i (cut_data),
        .vs_o   (filt_vs),
        .de_o   (filt_de),
        .data_o (filt_data)
    );

    // ---------------------------------------------------------------------
    // output side, blank fill and pack (1 cycle)
    // ---------------------------------------------------------------------
    vp_fill_blank #(
        .H_DISP(H_DISP)
    ) u_fill_blank (
        .clk_vpm(clk_vpm),
        .rst_i  (rst_i),
        .vs_i   (filt_vs),
        .de_i   (filt_de),
        .data_i (filt_data),
        .vs_o   (vp_vs_o),
        .de_o   (vp_de_o),
        .data_o (vp_data_o)
    );

endmodule

`default_nettype wire

// ==== rtl/vp_fill_blank.sv ====
`default_nettype none

`include "vp_config.svh"

module vp_fill_blank #(
    parameter int H_DISP = `VP_H_DISP_DEFAULT
) (
    input  wire              clk_vpm,
    input  wire              rst_i,

    // filtered rgb888 stream
    input  wire              vs_i,
    input  wire              de_i,
    input  wire vp_pkg::rgb888_t data_i,

    // full width rgb565 stream, one cycle later
    output logic             vs_o,
    output logic             de_o,
    output vp_pkg::rgb565_t  data_o
);

    // pixels sent so far in this line, real and padding
    vp_pkg::coord_t cnt;
    logic           de_d;
    logic           pad_run;

    // line ended short, keep going with black
    assign pad_run = !de_i && (cnt != '0) && (cnt < H_DISP);

    // ---------------------------------------------------------------------
    // line length counter
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_vpm) begin
        if (rst_i) begin
            cnt  <= '0;
            de_d <= 1'b0;
        end else begin
            de_d <= de_i;
            if (de_i) begin
                // rising de starts a fresh line
                cnt <= de_d ? vp_pkg::coord_t'(cnt + 1'b1) : vp_pkg::coord_t'(1);
            end else if (pad_run) begin
                cnt <= vp_pkg::coord_t'(cnt + 1'b1);
            end else begin
                cnt <= '0;
            end
        end
    end

    // ---------------------------------------------------------------------
    // output and pack
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_vpm) begin
        if (rst_i) begin
            vs_o <= 1'b0;
            de_o <= 1'b0;
        end else begin
            vs_o <= vs_i;
            de_o <= de_i || pad_run;
        end
    end

    // top 5/6/5 bits per channel, black while padding
    always_ff @(posedge clk_vpm) begin
        if (de_i) begin
            data_o <= {data_i[23:19], data_i[15:10], data_i[7:3]};
        end else begin
            data_o <= '0;
        end
    end

    // next line must wait until padding reaches full width
    a_no_de_in_pad : assert property (
        @(posedge clk_vpm) disable iff (rst_i)
        pad_run |=> (!de_i || cnt >= H_DISP)
    ) else $error("input de arrived while padding a line");

endmodule

`default_nettype wire

// ==== rtl/vp_line_filter.sv ====
`default_nettype none

module vp_line_filter (
    input  wire                   clk_vpm,
    input  wire                   rst_i,

    // filter select, held steady over a line
    input  wire vp_pkg::filter_mode_t mode_i,

    // rgb888 stream in
    input  wire                   vs_i,
    input  wire                   de_i,
    input  wire vp_pkg::rgb888_t  data_i,

    // filtered stream, two cycles later
    output logic                  vs_o,
    output logic                  de_o,
    output vp_pkg::rgb888_t       data_o
);

    // pix_d1 is the window center, pix_d2 its left neighbor
    // data_i supplies the right neighbor
    vp_pkg::rgb888_t pix_d1;
    vp_pkg::rgb888_t pix_d2;
    logic            de_d1;
    logic            de_d2;
    logic            vs_d1;
    logic            vs_d2;

    vp_pkg::rgb888_t win_l;
    vp_pkg::rgb888_t win_c;
    vp_pkg::rgb888_t win_r;
    vp_pkg::rgb888_t filt;

    // ---------------------------------------------------------------------
    // per channel kernels
    // ---------------------------------------------------------------------

    // 1-2-1 weighting, result truncated
    function automatic logic [7:0] gauss3(input logic [7:0] l, input logic [7:0] c,
                                          input logic [7:0] r);
        logic [9:0] sum;
        sum = {2'b00, l} + {1'b0, c, 1'b0} + {2'b00, r};
        return sum[9:2];
    endfunction

    // middle value of three
    function automatic logic [7:0] median3(input logic [7:0] l, input logic [7:0] c,
                                           input logic [7:0] r);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = (l < c) ? l : c;
        hi = (l < c) ? c : l;
        if (r < lo) begin
            return lo;
        end else if (r > hi) begin
            return hi;
        end
        return r;
    endfunction

    // ---------------------------------------------------------------------
    // window shift and control delay
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_vpm) begin
        if (rst_i) begin
            de_d1 <= 1'b0;
            de_d2 <= 1'b0;
            vs_d1 <= 1'b0;
            vs_d2 <= 1'b0;
        end else begin
            de_d1 <= de_i;
            de_d2 <= de_d1;
            vs_d1 <= vs_i;
            vs_d2 <= vs_d1;
        end
    end

    always_ff @(posedge clk_vpm) begin
        pix_d1 <= data_i;
        pix_d2 <= pix_d1;
    end

    // edge replication
    // de_d2 low means the center is the first pixel of its line,
    // de_i low means it is the last one
    always_comb begin
        win_c = pix_d1;
        win_l = de_d2 ? pix_d2 : pix_d1;
        win_r = de_i ? data_i : pix_d1;
    end

    // ---------------------------------------------------------------------
    // kernel select
    // ---------------------------------------------------------------------
    always_comb begin
        filt = win_c;
        for (int ch = 0; ch < 3; ch++) begin
            case (mode_i)
                vp_pkg::MODE_GAUSS: begin
                    filt[ch*8 +: 8] = gauss3(win_l[ch*8 +: 8], win_c[ch*8 +: 8],
                                             win_r[ch*8 +: 8]);
                end
                vp_pkg::MODE_MEDIAN: begin
                    filt[ch*8 +: 8] = median3(win_l[ch*8 +: 8], win_c[ch*8 +: 8],
                                              win_r[ch*8 +: 8]);
                end
                // 00 and 11 pass the center through
                default: begin
                    filt[ch*8 +: 8] = win_c[ch*8 +: 8];
                end
            endcase
        end
    end

    // result register, lines up with de_d2
    always_ff @(posedge clk_vpm) begin
        data_o <= filt;
    end

    assign de_o = de_d2;
    assign vs_o = vs_d2;

    // the kernel for the last center is picked one cycle after de falls,
    // so mode has to hold from the first pixel until then
    a_mode_stable : assert property (
        @(posedge clk_vpm) disable iff (rst_i)
        (de_i && de_d1) || (!de_i && de_d1) |-> $stable(mode_i)
    ) else $error("filter mode changed inside a line");

endmodule

`default_nettype wire

// ==== rtl/vp_image_cut.sv ====
`default_nettype none

`include "vp_config.svh"

module vp_image_cut #(
    parameter int H_DISP = `VP_H_DISP_DEFAULT
) (
    input  wire              clk_vpm,
    input  wire              rst_i,

    // incoming rgb565 stream
    input  wire              vs_i,
    input  wire              de_i,
    input  wire vp_pkg::rgb565_t data_i,

    // crop window, start inclusive and end exclusive
    input  wire vp_pkg::coord_t  start_x_i,
    input  wire vp_pkg::coord_t  start_y_i,
    input  wire vp_pkg::coord_t  end_x_i,
    input  wire vp_pkg::coord_t  end_y_i,

    // cropped rgb888 stream, one cycle later
    output logic             vs_o,
    output logic             de_o,
    output vp_pkg::rgb888_t  data_o
);

    vp_pkg::cut_state_e state;
    vp_pkg::coord_t     x_cnt;
    vp_pkg::coord_t     y_cnt;
    logic               de_d;
    logic               in_window;

    // ---------------------------------------------------------------------
    // position tracking
    // ---------------------------------------------------------------------

    // x_cnt is the x of the pixel now on data_i
    // y_cnt restarts on vs and steps on each falling edge of de
    always_ff @(posedge clk_vpm) begin
        if (rst_i) begin
            x_cnt <= '0;
            y_cnt <= '0;
            de_d  <= 1'b0;
            state <= vp_pkg::CUT_WAIT_FRAME;
        end else begin
            de_d <= de_i;
            if (de_i) begin
                x_cnt <= vp_pkg::coord_t'(x_cnt + 1'b1);
            end else begin
                x_cnt <= '0;
            end
            if (vs_i) begin
                y_cnt <= '0;
            end else if (de_d && !de_i) begin
                y_cnt <= vp_pkg::coord_t'(y_cnt + 1'b1);
            end
            // a stream joined mid frame is held off until the next vs
            if (state == vp_pkg::CUT_WAIT_FRAME && vs_i) begin
                state <= vp_pkg::CUT_ACTIVE;
            end
        end
    end

    // window test on the current pixel
    assign in_window = (x_cnt >= start_x_i) && (x_cnt < end_x_i) &&
                       (y_cnt >= start_y_i) && (y_cnt < end_y_i);

    // ---------------------------------------------------------------------
    // output register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_vpm) begin
        if (rst_i) begin
            vs_o <= 1'b0;
            de_o <= 1'b0;
        end else begin
            vs_o <= vs_i;
            de_o <= de_i && in_window && (state == vp_pkg::CUT_ACTIVE);
        end
    end

    // zero pad each channel into the low bits
    always_ff @(posedge clk_vpm) begin
        data_o <= {data_i[15:11], 3'b000, data_i[10:5], 2'b00, data_i[4:0], 3'b000};
    end

    // line never longer than the display width
    a_line_len : assert property (
        @(posedge clk_vpm) disable iff (rst_i)
        de_i |-> (x_cnt < H_DISP)
    ) else $error("input line longer than H_DISP");

endmodule

`default_nettype wire

// ==== rtl/vp_pkg.sv ====
`default_nettype none

`include "vp_config.svh"

package vp_pkg;

    // ---------------------------------------------------------------------
    // pixel formats
    // ---------------------------------------------------------------------

    // stream format at the ports, r[15:11] g[10:5] b[4:0]
    typedef logic [15:0] rgb565_t;

    // internal format, r[23:16] g[15:8] b[7:0]
    typedef logic [23:0] rgb888_t;

    // x or y position inside a frame
    typedef logic [`VP_COORD_W-1:0] coord_t;

    // ---------------------------------------------------------------------
    // filter select
    // ---------------------------------------------------------------------
    typedef logic [1:0] filter_mode_t;

    // 00 and 11 both mean bypass
    localparam filter_mode_t MODE_GAUSS  = 2'b01;
    localparam filter_mode_t MODE_MEDIAN = 2'b10;

    // crop FSM, waits for a frame start before it lets pixels through
    typedef enum logic {
        CUT_WAIT_FRAME,
        CUT_ACTIVE
    } cut_state_e;

endpackage

`default_nettype wire

// ==== rtl/vp_config.svh ====
`ifndef VP_CONFIG_SVH
`define VP_CONFIG_SVH

// ---------------------------------------------------------------------
// video path sizing
// ---------------------------------------------------------------------

// width of every pixel and line coordinate
// 11 bits cover up to 2047 pixels or lines
`define VP_COORD_W 11

// active pixels per output line
// blank fill pads every line up to this width
`define VP_H_DISP_DEFAULT 1280

// active lines per frame
// nothing in the path depends on it, the crop window limits lines at run time
`define VP_V_DISP_DEFAULT 720

`endif
